//--- common/cnn_pkg.sv
// shared types of the CNN front end
// import inside the module body, use cnn_pkg:: names in port lists
`include "cnn_settings.svh"

package cnn_pkg;

    // one signed pixel of a stream
    typedef logic signed [`CNN_DATA_WIDTH-1:0] pixel_t;

    // sum of the nine products
    typedef logic signed [`CNN_ACC_WIDTH-1:0] acc_t;

    // nine signed taps, tap 0 = top-left in the low byte
    typedef logic [9*`CNN_DATA_WIDTH-1:0] kernel_t;

    // nine window pixels, same order as the kernel taps
    typedef logic [9*`CNN_DATA_WIDTH-1:0] window_t;

    // raster position counters
    typedef logic [2:0] col_cnt_t;
    typedef logic [2:0] row_cnt_t;

    // concatenator: idle or emitting the held right value
    typedef enum logic {
        CONCAT_IDLE,
        CONCAT_RIGHT
    } concat_state_t;

endpackage

//--- common/cnn_settings.svh
// frame geometry, arithmetic widths and fixed kernels of the CNN front end
// include wherever a `CNN_ value is needed; the types live in cnn_pkg
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// pixel stream
`define CNN_DATA_WIDTH      8
`define CNN_FRAME_COLS      6
`define CNN_FRAME_ROWS      5

// accumulator and relu
`define CNN_ACC_WIDTH       20
`define CNN_ACC_SHIFT       3
`define CNN_RELU_MAX        127

// kernels, row-major, top-left tap in the lowest byte
// left: vertical gradient (1 2 1 / 0 0 0 / -1 -2 -1)
`define CNN_KERNEL_LEFT     72'hFF_FE_FF_00_00_00_01_02_01
// right: smoothing (1 2 1 / 2 4 2 / 1 2 1)
`define CNN_KERNEL_RIGHT    72'h01_02_01_02_04_02_01_02_01

`endif

//--- conv_layer/conv_layer.sv
// one 3x3 convolution layer: window, multiply-accumulate, shift and relu clamp
// data_valid_o follows the completing input pixel by three cycles
`timescale 1ns/1ps
`include "cnn_settings.svh"

module conv_layer #(
    parameter cnn_pkg::kernel_t KERNEL = `CNN_KERNEL_LEFT
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  cnn_pkg::pixel_t data_i,
    input  logic            data_valid_i,
    input  logic            sop_i,
    input  logic            eop_i,
    input  logic            sof_i,
    input  logic            eof_i,
    output cnn_pkg::pixel_t data_o,
    output logic            data_valid_o,
    output logic            sop_o,
    output logic            eop_o,
    output logic            sof_o,
    output logic            eof_o
);
    import cnn_pkg::*;

    // stage 1, window builder
    window_t window;
    logic    win_valid;
    logic    win_sop, win_eop, win_sof, win_eof;
    // stage 2, products and sum
    acc_t    mac_sum;
    acc_t    acc_q;
    logic    acc_valid_q;
    logic    acc_sop_q, acc_eop_q, acc_sof_q, acc_eof_q;
    // stage 3, shift and clamp
    acc_t    acc_shifted;
    pixel_t  relu;

    window_3x3 i_window_3x3 (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .data_i       ( data_i       ),
        .data_valid_i ( data_valid_i ),
        .sop_i        ( sop_i        ),
        .sof_i        ( sof_i        ),
        .eop_i        ( eop_i        ),
        .eof_i        ( eof_i        ),
        .window_o     ( window       ),
        .win_valid_o  ( win_valid    ),
        .sop_o        ( win_sop      ),
        .eop_o        ( win_eop      ),
        .sof_o        ( win_sof      ),
        .eof_o        ( win_eof      )
    );

    ////////////////////////////////////////////////////////////////////////////
    // multiply-accumulate, taps sign-extended before the product
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        mac_sum = '0;
        for (int i = 0; i < 9; i++) begin
            mac_sum = mac_sum
                + acc_t'(pixel_t'(window[i*`CNN_DATA_WIDTH +: `CNN_DATA_WIDTH]))
                * acc_t'(pixel_t'(KERNEL[i*`CNN_DATA_WIDTH +: `CNN_DATA_WIDTH]));
        end
    end

    // arithmetic shift, then clamp into 0..RELU_MAX
    always_comb begin
        acc_shifted = acc_q >>> `CNN_ACC_SHIFT;
        if (acc_shifted < 0) begin
            relu = '0;
        end else if (acc_shifted > acc_t'(`CNN_RELU_MAX)) begin
            relu = pixel_t'(`CNN_RELU_MAX);
        end else begin
            relu = acc_shifted[`CNN_DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        acc_q  <= mac_sum;
        data_o <= relu;
    end

    // valid and markers ride along with the data
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            {acc_valid_q, acc_sop_q, acc_eop_q, acc_sof_q, acc_eof_q} <= '0;
            {data_valid_o, sop_o, eop_o, sof_o, eof_o}                <= '0;
        end else begin
            {acc_valid_q, acc_sop_q, acc_eop_q, acc_sof_q, acc_eof_q} <=
                {win_valid, win_sop, win_eop, win_sof, win_eof};
            {data_valid_o, sop_o, eop_o, sof_o, eof_o} <=
                {acc_valid_q, acc_sop_q, acc_eop_q, acc_sof_q, acc_eof_q};
        end
    end

endmodule

//--- conv_layer/window_3x3.sv
// builds a 3x3 window from a raster pixel stream, valid convolution only
// window_o and the markers are registered, one cycle after the completing pixel
`timescale 1ns/1ps
`include "cnn_settings.svh"

module window_3x3 (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  cnn_pkg::pixel_t  data_i,
    input  logic             data_valid_i,
    input  logic             sop_i,
    input  logic             sof_i,
    input  logic             eop_i,
    input  logic             eof_i,
    output cnn_pkg::window_t window_o,
    output logic             win_valid_o,
    output logic             sop_o,
    output logic             eop_o,
    output logic             sof_o,
    output logic             eof_o
);
    import cnn_pkg::*;

    // line_buf0 holds row r-1, line_buf1 holds row r-2
    pixel_t   line_buf0 [`CNN_FRAME_COLS];
    pixel_t   line_buf1 [`CNN_FRAME_COLS];
    // win_q[row][col], row 0 is the oldest row, col 0 the oldest column
    pixel_t   win_q [3][3];
    // next expected column, row of the last pixel
    col_cnt_t col_cnt_q;
    row_cnt_t row_cnt_q;
    col_cnt_t cur_col;
    row_cnt_t cur_row;
    logic     complete;

    ////////////////////////////////////////////////////////////////////////////
    // position of the incoming pixel
    ////////////////////////////////////////////////////////////////////////////
    assign cur_col  = sop_i ? '0 : col_cnt_q;
    // new row starts on sop, new frame on sof
    assign cur_row  = sof_i ? '0 : (sop_i ? row_cnt_t'(row_cnt_q + 1'b1) : row_cnt_q);
    assign complete = data_valid_i && (cur_row >= row_cnt_t'(2)) && (cur_col >= col_cnt_t'(2));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            col_cnt_q   <= '0;
            row_cnt_q   <= '0;
            win_valid_o <= 1'b0;
            sop_o       <= 1'b0;
            eop_o       <= 1'b0;
            sof_o       <= 1'b0;
            eof_o       <= 1'b0;
        end else begin
            if (data_valid_i) begin
                col_cnt_q <= col_cnt_t'(cur_col + 1'b1);
                row_cnt_q <= cur_row;
            end
            win_valid_o <= complete;
            // first window of a row sits at input column 2
            sop_o       <= complete && (cur_col == col_cnt_t'(2));
            sof_o       <= complete && (cur_col == col_cnt_t'(2)) && (cur_row == row_cnt_t'(2));
            eop_o       <= complete && eop_i;
            eof_o       <= complete && eof_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // line buffers and shift window
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (data_valid_i) begin
            line_buf0[cur_col] <= data_i;
            line_buf1[cur_col] <= line_buf0[cur_col];
            for (int r = 0; r < 3; r++) begin
                win_q[r][0] <= win_q[r][1];
                win_q[r][1] <= win_q[r][2];
            end
            // new column, top to bottom
            win_q[0][2] <= line_buf1[cur_col];
            win_q[1][2] <= line_buf0[cur_col];
            win_q[2][2] <= data_i;
        end
    end

    // pack row-major, top-left in the low byte
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                window_o[(3*r+c)*`CNN_DATA_WIDTH +: `CNN_DATA_WIDTH] = win_q[r][c];
            end
        end
    end

endmodule

//--- flist.f
+incdir+common
common/cnn_pkg.sv
conv_layer/window_3x3.sv
conv_layer/conv_layer.sv
src/concat_channels.sv
src/conv_nn.sv
testbench/conv_nn_assert.sv
testbench/conv_nn_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the conv_nn testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module conv_nn_tb \
    -o conv_nn_sim

sim_out=$(./obj_dir/conv_nn_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

//--- src/concat_channels.sv
// interleaves two lockstep channels into one stream, left then right
// sop/sof go with the left value, eop/eof with the right one
`timescale 1ns/1ps

module concat_channels (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  cnn_pkg::pixel_t data_l_i,
    input  cnn_pkg::pixel_t data_r_i,
    input  logic            data_valid_i,
    input  logic            sop_i,
    input  logic            eop_i,
    input  logic            sof_i,
    input  logic            eof_i,
    output cnn_pkg::pixel_t data_o,
    output logic            data_valid_o,
    output logic            sop_o,
    output logic            eop_o,
    output logic            sof_o,
    output logic            eof_o
);
    import cnn_pkg::*;

    concat_state_t state_q;
    // right value and its end markers, emitted one cycle later
    pixel_t        data_r_q;
    logic          eop_q;
    logic          eof_q;

    ////////////////////////////////////////////////////////////////////////////
    // two-state sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= CONCAT_IDLE;
            eop_q        <= 1'b0;
            eof_q        <= 1'b0;
            data_valid_o <= 1'b0;
            {sop_o, eop_o, sof_o, eof_o} <= '0;
        end else begin
            case (state_q)
                CONCAT_RIGHT: begin
                    state_q      <= CONCAT_IDLE;
                    data_valid_o <= 1'b1;
                    {sop_o, eop_o, sof_o, eof_o} <= {1'b0, eop_q, 1'b0, eof_q};
                end
                default: begin
                    // left goes out now, right is held
                    if (data_valid_i) begin
                        state_q <= CONCAT_RIGHT;
                        eop_q   <= eop_i;
                        eof_q   <= eof_i;
                    end
                    data_valid_o <= data_valid_i;
                    {sop_o, eop_o, sof_o, eof_o} <=
                        {sop_i & data_valid_i, 1'b0, sof_i & data_valid_i, 1'b0};
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == CONCAT_IDLE && data_valid_i) begin
            data_r_q <= data_r_i;
        end
        data_o <= (state_q == CONCAT_RIGHT) ? data_r_q : data_l_i;
    end

endmodule

//--- src/conv_nn.sv
// two-branch convolutional front end: left and right layers, then concatenation
// left output 4 cycles after the completing pixel, right output 5 cycles after
`timescale 1ns/1ps
`include "cnn_settings.svh"

module conv_nn (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  cnn_pkg::pixel_t data_l_i,
    input  cnn_pkg::pixel_t data_r_i,
    input  logic            data_valid_i,
    input  logic            sop_i,
    input  logic            eop_i,
    input  logic            sof_i,
    input  logic            eof_i,
    output cnn_pkg::pixel_t data_o,
    output logic            data_valid_o,
    output logic            sop_o,
    output logic            eop_o,
    output logic            sof_o,
    output logic            eof_o
);
    import cnn_pkg::*;

    // left branch carries the shared valid and markers
    pixel_t data_l;
    logic   valid_l;
    logic   sop_l, eop_l, sof_l, eof_l;
    // right branch runs in lockstep, only its data is needed
    pixel_t data_r;

    ////////////////////////////////////////////////////////////////////////////
    // layers
    ////////////////////////////////////////////////////////////////////////////
    conv_layer #(.KERNEL(`CNN_KERNEL_LEFT)) i_conv_layer_l (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .data_i (data_l_i), .data_valid_i (data_valid_i),
        .sop_i (sop_i), .eop_i (eop_i), .sof_i (sof_i), .eof_i (eof_i),
        .data_o (data_l), .data_valid_o (valid_l),
        .sop_o (sop_l), .eop_o (eop_l), .sof_o (sof_l), .eof_o (eof_l)
    );

    conv_layer #(.KERNEL(`CNN_KERNEL_RIGHT)) i_conv_layer_r (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .data_i (data_r_i), .data_valid_i (data_valid_i),
        .sop_i (sop_i), .eop_i (eop_i), .sof_i (sof_i), .eof_i (eof_i),
        .data_o (data_r), .data_valid_o (),
        .sop_o (), .eop_o (), .sof_o (), .eof_o ()
    );

    // interleave into the output stream
    concat_channels i_concat_channels (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .data_l_i (data_l), .data_r_i (data_r), .data_valid_i (valid_l),
        .sop_i (sop_l), .eop_i (eop_l), .sof_i (sof_l), .eof_i (eof_l),
        .data_o (data_o), .data_valid_o (data_valid_o),
        .sop_o (sop_o), .eop_o (eop_o), .sof_o (sof_o), .eof_o (eof_o)
    );

endmodule

//--- testbench/conv_nn_assert.sv
// protocol and range checks on the conv_nn ports
// attached to every conv_nn instance by the bind at the bottom
`timescale 1ns/1ps
`include "cnn_settings.svh"

module conv_nn_assert (
    input logic            clk_i,
    input logic            rst_n_i,
    input logic            in_valid_i,
    input cnn_pkg::pixel_t out_data_i,
    input logic            out_valid_i,
    input logic            out_sop_i,
    input logic            out_eop_i,
    input logic            out_sof_i,
    input logic            out_eof_i
);

    // input strobe needs an idle cycle after every pixel
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i |=> !in_valid_i)
        else $error("data_valid_i high on two consecutive cycles");

    // markers only on a valid output
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_sop_i || out_eop_i || out_sof_i || out_eof_i) |-> out_valid_i)
        else $error("output marker high without data_valid_o");

    // relu output range, negatives show up above the limit here
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i |-> ({1'b0, out_data_i} <= 9'(`CNN_RELU_MAX)))
        else $error("data_o outside the relu range");

endmodule

bind conv_nn conv_nn_assert i_conv_nn_assert (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .in_valid_i  ( data_valid_i ),
    .out_data_i  ( data_o       ),
    .out_valid_i ( data_valid_o ),
    .out_sop_i   ( sop_o        ),
    .out_eop_i   ( eop_o        ),
    .out_sof_i   ( sof_o        ),
    .out_eof_i   ( eof_o        )
);

//--- testbench/conv_nn_tb.sv
// testbench for conv_nn: one frame with every-other-cycle input, then the same
// frame with random gaps; outputs, markers and frame-one latency are checked
`timescale 1ns/1ps
`include "cnn_settings.svh"

module conv_nn_tb;
    import cnn_pkg::*;

    localparam int N_PIX          = `CNN_FRAME_ROWS * `CNN_FRAME_COLS;
    localparam int OUT_COLS       = `CNN_FRAME_COLS - 2;
    localparam int N_WIN          = (`CNN_FRAME_ROWS - 2) * OUT_COLS;
    localparam int N_OUT          = 2 * N_WIN;
    localparam int N_FRAMES       = 2;
    localparam int N_WORDS        = 2 * N_PIX + N_OUT;
    localparam int RESET_CYCLES   = 5;
    localparam int MAX_GAP        = 4;
    // both frames at worst-case spacing plus slack, doubled
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + 2 * N_PIX + (MAX_GAP + 1) * N_PIX + 20);

    logic       clk;
    logic       rst_n;
    pixel_t     in_data_l;
    pixel_t     in_data_r;
    logic       in_valid;
    logic       in_sop, in_eop, in_sof, in_eof;
    pixel_t     out_data;
    logic       out_valid;
    logic       out_sop, out_eop, out_sof, out_eof;

    // raw file words, then split into stimulus and expected lists
    logic [7:0] file_words [N_WORDS];
    logic [7:0] pix_l [N_PIX];
    logic [7:0] pix_r [N_PIX];
    logic [7:0] exp_out [N_OUT];
    // cycle of each completing input in frame one
    int         complete_cycle [N_WIN];
    int         cycle_cnt = 0;
    int         out_count = 0;
    int         win_count = 0;
    integer     seed;

    conv_nn i_dut (
        .clk_i (clk), .rst_n_i (rst_n),
        .data_l_i (in_data_l), .data_r_i (in_data_r), .data_valid_i (in_valid),
        .sop_i (in_sop), .eop_i (in_eop), .sof_i (in_sof), .eof_i (in_eof),
        .data_o (out_data), .data_valid_o (out_valid),
        .sop_o (out_sop), .eop_o (out_eop), .sof_o (out_sof), .eof_o (out_eof)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED: %s expected 0x%0h actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the expected outputs did not all arrive in time");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        {in_sop, in_eop, in_sof, in_eof} = 4'b0;
    endtask

    task automatic drive_pixel(input int p, input bit track_latency);
        int r;
        int c;
        r = p / `CNN_FRAME_COLS;
        c = p % `CNN_FRAME_COLS;
        @(posedge clk);
        #1;
        in_data_l = pix_l[p];
        in_data_r = pix_r[p];
        in_valid  = 1'b1;
        in_sop    = (c == 0);
        in_eop    = (c == `CNN_FRAME_COLS - 1);
        in_sof    = (p == 0);
        in_eof    = (p == N_PIX - 1);
        // this pixel closes a window
        if (track_latency && r >= 2 && c >= 2) begin
            complete_cycle[win_count] = cycle_cnt;
            win_count = win_count + 1;
        end
    endtask

    task automatic drive_frame(input bit random_gaps);
        int gap;
        for (int p = 0; p < N_PIX; p++) begin
            drive_pixel(p, !random_gaps);
            gap = random_gaps ? 1 + int'({$random(seed)} % MAX_GAP) : 1;
            repeat (gap) drive_idle();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin : monitor
        int  k;
        int  w;
        int  col;
        bit  right;
        if (win_count == 0) begin
            // no window completed yet, everything quiet
            check_value("data_valid_o", 32'(out_valid), 32'd0);
            check_value("sop_o", 32'(out_sop), 32'd0);
            check_value("eop_o", 32'(out_eop), 32'd0);
            check_value("sof_o", 32'(out_sof), 32'd0);
            check_value("eof_o", 32'(out_eof), 32'd0);
        end else if (out_valid) begin
            if (out_count >= N_FRAMES * N_OUT) begin
                fail_run("an output arrived after all expected outputs were seen");
            end else begin
                k     = out_count % N_OUT;
                w     = k / 2;
                col   = w % OUT_COLS;
                right = (k % 2) == 1;
                check_value("data_o", {24'h0, out_data}, {24'h0, exp_out[k]});
                check_value("sop_o", 32'(out_sop), 32'(!right && col == 0));
                check_value("eop_o", 32'(out_eop), 32'(right && col == OUT_COLS - 1));
                check_value("sof_o", 32'(out_sof), 32'(k == 0));
                check_value("eof_o", 32'(out_eof), 32'(k == N_OUT - 1));
                // fixed latency only in the evenly spaced frame
                if (out_count < N_OUT) begin
                    check_value("output cycle", cycle_cnt, complete_cycle[w] + 4 + k % 2);
                end
                out_count = out_count + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_n     = 1'b0;
        in_data_l = '0;
        in_data_r = '0;
        in_valid  = 1'b0;
        {in_sop, in_eop, in_sof, in_eof} = 4'b0;
        seed      = 70;
        $readmemh("testbench/conv_nn_testdata.txt", file_words);
        for (int i = 0; i < N_PIX; i++) begin
            pix_l[i] = file_words[2*i];
            pix_r[i] = file_words[2*i+1];
        end
        for (int i = 0; i < N_OUT; i++) begin
            exp_out[i] = file_words[2*N_PIX+i];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) drive_idle();
        drive_frame(1'b0);
        repeat (4) drive_idle();
        drive_frame(1'b1);
        while (out_count < N_FRAMES * N_OUT) begin
            @(posedge clk);
        end
        // drain, catches stray outputs
        repeat (20) @(posedge clk);
        if (out_count == N_FRAMES * N_OUT) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            fail_run("the output count does not match the two frames");
        end
    end

endmodule

//--- testbench/conv_nn_testdata.txt
// frame input, one pixel pair per line in raster order: left right (signed hex)
// 5 rows of 6 pixels, then the 24 expected outputs, left then right per window
64 7F // row 0
64 7F
64 7F
9C 00
9C 00
9C 00
05 7F // row 1
FB 7F
07 7F
F9 00
09 00
F7 00
9C 7F // row 2
9C 7F
9C 7F
64 F6
64 F6
64 F6
EC 08 // row 3
E2 10
D8 18
CE 20
C4 28
BA 30
64 80 // row 4
78 80
7F 80
80 80
CE 80
00 80
// expected outputs, output row 0
64
7F
32
7F
00
3B
00
00
// output row 1
0F
7F
14
7F
19
38
1E
0A
// output row 2
00
0F
00
06
2F
00
4E
00
